/* logic/camera_pkg.sv */
package camera_pkg;

  // coordinate widths, as in the vga counters
  localparam int x_w = 11;
  localparam int y_w = 10;

  // flops per camera pin into the 65 mhz domain
  localparam int sync_stages = 2;

  // rgb565 word, red in the top bits
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // camera pins after the synchroniser
  typedef struct packed {
    logic       pclk;
    logic       vsync;
    logic       href;
    logic [7:0] data;
  } cam_pins_t;

  // one pixel moving down the pipe, or a frame end marker
  typedef struct packed {
    logic           valid;
    logic           frame_end;
    rgb565_t        pixel;
    logic [x_w-1:0] x;
    logic [y_w-1:0] y;
  } pix_beat_t;

  // which half of the 565 word is expected next
  typedef enum logic {
    hi_byte,
    lo_byte
  } byte_phase_e;

endpackage

/* logic/track_pkg.sv */
package track_pkg;

  localparam int chroma_w = 8;
  localparam int bound_w = 3;
  localparam int sum_w = 32;
  localparam int cnt_w = 20;
  // bit counter width for the serial divider
  localparam int div_cnt_w = $clog2(sum_w + 1);

  // chroma bias, added after the >> 8
  localparam int chroma_offset = 128;

  // cr = (128 r - 107 g - 21 b) >> 8
  localparam int cr_coef_r = 128;
  localparam int cr_coef_g = 107;
  localparam int cr_coef_b = 21;
  // cb = (128 b - 43 r - 85 g) >> 8
  localparam int cb_coef_r = 43;
  localparam int cb_coef_g = 85;
  localparam int cb_coef_b = 128;

  // thresholded pixel with its coordinates
  typedef struct packed {
    logic                       valid;
    logic                       frame_end;
    logic                       mask_cr;
    logic                       mask_cb;
    logic [camera_pkg::x_w-1:0] x;
    logic [camera_pkg::y_w-1:0] y;
  } mask_beat_t;

  // center of mass of one channel
  typedef struct packed {
    logic [camera_pkg::x_w-1:0] x;
    logic [camera_pkg::y_w-1:0] y;
  } centroid_t;

  typedef enum logic {
    accum_idle,
    accum_divide
  } accum_state_e;

  // threshold window on the top chroma bits
  typedef struct packed {
    logic [bound_w-1:0] lower;
    logic [bound_w-1:0] upper;
  } bounds_t;

endpackage

/* logic/mean_divider.sv */
`timescale 1ns/100ps

module mean_divider (
  input  logic                        clk_65mhz,
  input  logic                        sys_rst,
  input  logic                        start,
  input  logic [track_pkg::sum_w-1:0] dividend,
  input  logic [track_pkg::cnt_w-1:0] divisor,
  output logic [track_pkg::sum_w-1:0] quotient,
  output logic                        done
);
  import track_pkg::*;

  logic [cnt_w-1:0]     den;
  logic [cnt_w-1:0]     rem;
  logic [cnt_w:0]       trial;
  logic [div_cnt_w-1:0] bits_left;

  // remainder shifted left with the next dividend bit
  assign trial = {rem, quotient[sum_w-1]};

  // one quotient bit per cycle
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      bits_left <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        bits_left <= div_cnt_w'(sum_w);
      end else if (bits_left != '0) begin
        bits_left <= bits_left - 1'b1;
        if (bits_left == div_cnt_w'(1)) begin
          done <= 1'b1;
        end
      end
    end
  end

  // dividend shifts out the top as quotient bits shift in
  always_ff @(posedge clk_65mhz) begin
    if (start) begin
      den <= divisor;
      rem <= '0;
      quotient <= dividend;
    end else if (bits_left != '0) begin
      if (trial >= {1'b0, den}) begin
        rem <= cnt_w'(trial - {1'b0, den});
        quotient <= {quotient[sum_w-2:0], 1'b1};
      end else begin
        rem <= trial[cnt_w-1:0];
        quotient <= {quotient[sum_w-2:0], 1'b0};
      end
    end
  end

endmodule

/* logic/cam_capture.sv */
`timescale 1ns/100ps

module cam_capture (
  input  logic                  clk_65mhz,
  input  logic                  sys_rst,
  input  logic [7:0]            ja,
  input  logic [2:0]            jb,
  output camera_pkg::pix_beat_t beat
);
  import camera_pkg::*;

  cam_pins_t      sync_q [sync_stages];
  cam_pins_t      pins;
  logic           pclk_d;
  logic           href_d;
  logic           vsync_d;
  logic           pclk_rise;
  logic           href_fall;
  logic           vsync_rise;
  byte_phase_e    phase;
  logic [7:0]     hi_q;
  logic [x_w-1:0] x_cnt;
  logic [y_w-1:0] y_cnt;

  // two flop chain on every camera pin
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < sync_stages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= '{pclk: jb[0], vsync: jb[1], href: jb[2], data: ja};
      for (int i = 1; i < sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign pins = sync_q[sync_stages-1];

  // edges against last cycle's pins
  assign pclk_rise = pins.pclk & ~pclk_d;
  assign href_fall = ~pins.href & href_d;
  assign vsync_rise = pins.vsync & ~vsync_d;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pclk_d <= 1'b0;
      href_d <= 1'b0;
      vsync_d <= 1'b0;
      phase <= hi_byte;
      x_cnt <= '0;
      y_cnt <= '0;
      beat.valid <= 1'b0;
      beat.frame_end <= 1'b0;
    end else begin
      pclk_d <= pins.pclk;
      href_d <= pins.href;
      vsync_d <= pins.vsync;
      // beats are single cycle strobes
      beat.valid <= 1'b0;
      beat.frame_end <= 1'b0;
      if (vsync_rise) begin
        // new frame, marker beat carries valid low
        beat.frame_end <= 1'b1;
        x_cnt <= '0;
        y_cnt <= '0;
        phase <= hi_byte;
      end else if (href_fall) begin
        // end of line
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
        phase <= hi_byte;
      end else if (pclk_rise && pins.href) begin
        if (phase == hi_byte) begin
          hi_q <= pins.data;
          phase <= lo_byte;
        end else begin
          // second byte completes the 565 word
          beat.valid <= 1'b1;
          beat.pixel <= {hi_q, pins.data};
          beat.x <= x_cnt;
          beat.y <= y_cnt;
          x_cnt <= x_cnt + 1'b1;
          phase <= hi_byte;
        end
      end
    end
  end

endmodule

/* logic/chroma_mask.sv */
`timescale 1ns/100ps

module chroma_mask (
  input  logic                   clk_65mhz,
  input  logic                   sys_rst,
  input  camera_pkg::pix_beat_t  beat_in,
  input  track_pkg::bounds_t     bounds,
  output track_pkg::mask_beat_t  beat_out
);
  import camera_pkg::*;
  import track_pkg::*;

  logic [chroma_w-1:0] r8;
  logic [chroma_w-1:0] g8;
  logic [chroma_w-1:0] b8;
  logic [15:0]         cr_r_q;
  logic [15:0]         cr_g_q;
  logic [15:0]         cr_b_q;
  logic [15:0]         cb_r_q;
  logic [15:0]         cb_g_q;
  logic [15:0]         cb_b_q;
  logic                s1_valid;
  logic                s1_frame_end;
  logic [x_w-1:0]      s1_x;
  logic [y_w-1:0]      s1_y;
  logic signed [17:0]  cr_sum;
  logic signed [17:0]  cb_sum;
  logic [chroma_w-1:0] cr;
  logic [chroma_w-1:0] cb;

  // >> 8, add bias, clamp to a byte
  function automatic logic [chroma_w-1:0] bias_clamp(input logic signed [17:0] sum);
    logic signed [17:0] biased;
    biased = sum >>> 8;
    biased = biased + $signed(18'(chroma_offset));
    if (biased < 0) begin
      return '0;
    end else if (biased > 255) begin
      return '1;
    end
    return biased[chroma_w-1:0];
  endfunction

  // top chroma bits inside lower..upper
  function automatic logic in_window(input logic [chroma_w-1:0] chroma);
    logic [bound_w-1:0] top;
    top = chroma[chroma_w-1 -: bound_w];
    return (top >= bounds.lower) && (top <= bounds.upper);
  endfunction

  // 565 fields widened to 8 bits
  assign r8 = {beat_in.pixel.r, 3'b000};
  assign g8 = {beat_in.pixel.g, 2'b00};
  assign b8 = {beat_in.pixel.b, 3'b000};

  // stage 1 products
  always_ff @(posedge clk_65mhz) begin
    cr_r_q <= 16'(cr_coef_r * r8);
    cr_g_q <= 16'(cr_coef_g * g8);
    cr_b_q <= 16'(cr_coef_b * b8);
    cb_r_q <= 16'(cb_coef_r * r8);
    cb_g_q <= 16'(cb_coef_g * g8);
    cb_b_q <= 16'(cb_coef_b * b8);
    s1_x <= beat_in.x;
    s1_y <= beat_in.y;
  end

  // stage 2 weighted sums
  assign cr_sum = $signed({2'b00, cr_r_q}) - $signed({2'b00, cr_g_q})
                  - $signed({2'b00, cr_b_q});
  assign cb_sum = $signed({2'b00, cb_b_q}) - $signed({2'b00, cb_r_q})
                  - $signed({2'b00, cb_g_q});
  assign cr = bias_clamp(cr_sum);
  assign cb = bias_clamp(cb_sum);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      s1_valid <= 1'b0;
      s1_frame_end <= 1'b0;
      beat_out.valid <= 1'b0;
      beat_out.frame_end <= 1'b0;
      beat_out.mask_cr <= 1'b0;
      beat_out.mask_cb <= 1'b0;
    end else begin
      s1_valid <= beat_in.valid;
      s1_frame_end <= beat_in.frame_end;
      beat_out.valid <= s1_valid;
      // frame end rides along, never overtakes the last pixel
      beat_out.frame_end <= s1_frame_end;
      beat_out.mask_cr <= s1_valid && in_window(cr);
      beat_out.mask_cb <= s1_valid && in_window(cb);
      beat_out.x <= s1_x;
      beat_out.y <= s1_y;
    end
  end

endmodule

/* logic/centroid_accum.sv */
`timescale 1ns/100ps

module centroid_accum #(
  parameter bit use_cb = 1'b0
) (
  input  logic                  clk_65mhz,
  input  logic                  sys_rst,
  input  track_pkg::mask_beat_t beat,
  output track_pkg::centroid_t  com,
  output logic                  new_com
);
  import camera_pkg::*;
  import track_pkg::*;

  accum_state_e     state;
  logic             hit;
  logic [sum_w-1:0] sum_x;
  logic [sum_w-1:0] sum_y;
  logic [cnt_w-1:0] count;
  logic [sum_w-1:0] cap_x;
  logic [sum_w-1:0] cap_y;
  logic [cnt_w-1:0] cap_count;
  logic             start;
  logic [sum_w-1:0] quot_x;
  logic [sum_w-1:0] quot_y;
  logic             done_x;
  logic             done_y;

  // which mask this channel follows
  assign hit = use_cb ? beat.mask_cb : beat.mask_cr;

  // running sums over the frame
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end else if (beat.frame_end) begin
      // cleared every frame end, dropped if the dividers are busy
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end else if (hit) begin
      sum_x <= sum_x + sum_w'(beat.x);
      sum_y <= sum_y + sum_w'(beat.y);
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state <= accum_idle;
      start <= 1'b0;
      new_com <= 1'b0;
    end else begin
      start <= 1'b0;
      new_com <= 1'b0;
      case (state)
        accum_idle: begin
          // empty mask gives no result
          if (beat.frame_end && count != '0) begin
            cap_x <= sum_x;
            cap_y <= sum_y;
            cap_count <= count;
            start <= 1'b1;
            state <= accum_divide;
          end
        end
        accum_divide: begin
          // both dividers share one start, so their done strobes coincide
          if (done_x && done_y) begin
            // means fit the coordinate widths
            com.x <= quot_x[x_w-1:0];
            com.y <= quot_y[y_w-1:0];
            new_com <= 1'b1;
            state <= accum_idle;
          end
        end
        default: state <= accum_idle;
      endcase
    end
  end

  mean_divider div_x_i (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (start),
    .dividend  (cap_x),
    .divisor   (cap_count),
    .quotient  (quot_x),
    .done      (done_x)
  );

  mean_divider div_y_i (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (start),
    .dividend  (cap_y),
    .divisor   (cap_count),
    .quotient  (quot_y),
    .done      (done_y)
  );

endmodule

/* logic/hand_report.sv */
`timescale 1ns/100ps

module hand_report (
  input  logic                 clk_65mhz,
  input  logic                 sys_rst,
  input  track_pkg::centroid_t com_cr,
  input  logic                 new_com_cr,
  input  track_pkg::centroid_t com_cb,
  input  logic                 new_com_cb,
  output logic [11:0]          hand_x_left_bottom,
  output logic [11:0]          hand_y_left_bottom,
  output logic [11:0]          hand_x_left_top,
  output logic [11:0]          hand_y_left_top,
  output logic                 transmit_xy_update
);
  import track_pkg::*;

  centroid_t cr_q;
  centroid_t cb_q;
  logic      seen_cr;
  logic      seen_cb;
  logic      got_cr;
  logic      got_cb;

  // channel reported since last transmit, this cycle included
  assign got_cr = seen_cr | new_com_cr;
  assign got_cb = seen_cb | new_com_cb;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      cr_q <= '0;
      cb_q <= '0;
      seen_cr <= 1'b0;
      seen_cb <= 1'b0;
      transmit_xy_update <= 1'b0;
    end else begin
      if (new_com_cr) begin
        cr_q <= com_cr;
      end
      if (new_com_cb) begin
        cb_q <= com_cb;
      end
      // pulse once both are in, then start over
      if (got_cr && got_cb) begin
        transmit_xy_update <= 1'b1;
        seen_cr <= 1'b0;
        seen_cb <= 1'b0;
      end else begin
        transmit_xy_update <= 1'b0;
        seen_cr <= got_cr;
        seen_cb <= got_cb;
      end
    end
  end

  // camera axes swapped, cr is the bottom hand
  assign hand_x_left_bottom = 12'(cr_q.y);
  assign hand_y_left_bottom = 12'(cr_q.x);
  assign hand_x_left_top = 12'(cb_q.y);
  assign hand_y_left_top = 12'(cb_q.x);

endmodule

/* logic/hand_tracker.sv */
`timescale 1ns/100ps

module hand_tracker (
  input  logic        clk_65mhz,
  input  logic        sys_rst,
  input  logic [7:0]  ja,
  input  logic [2:0]  jb,
  input  logic [15:0] sw,
  output logic [11:0] hand_x_left_bottom,
  output logic [11:0] hand_y_left_bottom,
  output logic [11:0] hand_x_left_top,
  output logic [11:0] hand_y_left_top,
  output logic        transmit_xy_update
);
  import camera_pkg::*;
  import track_pkg::*;

  pix_beat_t  pix_beat;
  mask_beat_t mask_beat;
  bounds_t    bounds;
  centroid_t  com_cr;
  centroid_t  com_cb;
  logic       new_com_cr;
  logic       new_com_cb;

  // threshold window from the switches
  assign bounds.lower = sw[12:10];
  assign bounds.upper = sw[15:13];

  cam_capture cam_capture_i (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .ja        (ja),
    .jb        (jb),
    .beat      (pix_beat)
  );

  chroma_mask chroma_mask_i (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat_in   (pix_beat),
    .bounds    (bounds),
    .beat_out  (mask_beat)
  );

  // cr channel, left bottom hand
  centroid_accum #(.use_cb(1'b0)) accum_cr_i (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat      (mask_beat),
    .com       (com_cr),
    .new_com   (new_com_cr)
  );

  // cb channel, left top hand
  centroid_accum #(.use_cb(1'b1)) accum_cb_i (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat      (mask_beat),
    .com       (com_cb),
    .new_com   (new_com_cb)
  );

  hand_report hand_report_i (
    .clk_65mhz          (clk_65mhz),
    .sys_rst            (sys_rst),
    .com_cr             (com_cr),
    .new_com_cr         (new_com_cr),
    .com_cb             (com_cb),
    .new_com_cb         (new_com_cb),
    .hand_x_left_bottom (hand_x_left_bottom),
    .hand_y_left_bottom (hand_y_left_bottom),
    .hand_x_left_top    (hand_x_left_top),
    .hand_y_left_top    (hand_y_left_top),
    .transmit_xy_update (transmit_xy_update)
  );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  // half of the 8 ns period
  parameter int half_period = 4
) (
  output logic clk_65mhz
);

  initial begin
    clk_65mhz = 1'b0;
    forever #(half_period) clk_65mhz = ~clk_65mhz;
  end

endmodule

/* tests/tb_scoreboard.sv */
`timescale 1ns/100ps

module tb_scoreboard (
  input  logic                  clk_65mhz,
  input  logic                  sys_rst,
  input  camera_pkg::pix_beat_t rec,
  input  track_pkg::bounds_t    bounds,
  input  logic                  check_req,
  input  logic [11:0]           hand_x_left_bottom,
  input  logic [11:0]           hand_y_left_bottom,
  input  logic [11:0]           hand_x_left_top,
  input  logic [11:0]           hand_y_left_top,
  input  logic                  transmit_xy_update,
  output int                    exp_pulses,
  output int                    got_pulses,
  output int                    errors
);
  import camera_pkg::*;
  import track_pkg::*;

  // channel index 0 is cr, 1 is cb
  int sum_x [2];
  int sum_y [2];
  int count [2];
  // expected held outputs, already swapped
  int exp_hx [2];
  int exp_hy [2];
  bit pend [2];

  // chroma of one 565 word, widened, weighted, biased and clamped
  function automatic int chroma_of(input logic [15:0] pix, input int ch);
    int r8;
    int g8;
    int b8;
    int acc;
    r8 = int'(pix[15:11]) * 8;
    g8 = int'(pix[10:5]) * 4;
    b8 = int'(pix[4:0]) * 8;
    if (ch == 0) begin
      acc = 128 * r8 - 107 * g8 - 21 * b8;
    end else begin
      acc = 128 * b8 - 43 * r8 - 85 * g8;
    end
    // floor shift, then the bias
    acc = (acc >>> 8) + 128;
    if (acc < 0) begin
      acc = 0;
    end else if (acc > 255) begin
      acc = 255;
    end
    return acc;
  endfunction

  // top three chroma bits against the switch window
  function automatic bit in_window(input int chroma, input bounds_t b);
    int top;
    top = chroma / 32;
    return (top >= int'(b.lower)) && (top <= int'(b.upper));
  endfunction

  task automatic check_value(input string name, input logic [11:0] got, input int exp);
    if (got !== 12'(exp)) begin
      $display("ERR %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_outputs();
    check_value("hand_x_left_bottom", hand_x_left_bottom, exp_hx[0]);
    check_value("hand_y_left_bottom", hand_y_left_bottom, exp_hy[0]);
    check_value("hand_x_left_top", hand_x_left_top, exp_hx[1]);
    check_value("hand_y_left_top", hand_y_left_top, exp_hy[1]);
  endtask

  // floor means per channel, x output takes the y mean
  task automatic close_frame();
    for (int ch = 0; ch < 2; ch++) begin
      if (count[ch] != 0) begin
        exp_hx[ch] = sum_y[ch] / count[ch];
        exp_hy[ch] = sum_x[ch] / count[ch];
        pend[ch] = 1'b1;
      end
      sum_x[ch] = 0;
      sum_y[ch] = 0;
      count[ch] = 0;
    end
    // one transmit once both channels have reported
    if (pend[0] && pend[1]) begin
      exp_pulses++;
      pend[0] = 1'b0;
      pend[1] = 1'b0;
    end
  endtask

  always @(posedge clk_65mhz) begin
    if (sys_rst) begin
      for (int ch = 0; ch < 2; ch++) begin
        sum_x[ch] = 0;
        sum_y[ch] = 0;
        count[ch] = 0;
        exp_hx[ch] = 0;
        exp_hy[ch] = 0;
        pend[ch] = 1'b0;
      end
      exp_pulses = 0;
      got_pulses = 0;
      errors = 0;
    end else begin
      if (rec.valid) begin
        for (int ch = 0; ch < 2; ch++) begin
          if (in_window(chroma_of(rec.pixel, ch), bounds)) begin
            sum_x[ch] += int'(rec.x);
            sum_y[ch] += int'(rec.y);
            count[ch]++;
          end
        end
      end
      if (rec.frame_end) begin
        close_frame();
      end
      if (check_req) begin
        compare_outputs();
      end
      // outputs settle on the same edge as the pulse
      if (transmit_xy_update) begin
        got_pulses++;
        if (got_pulses > exp_pulses) begin
          $display("ERR %0t: transmit_xy_update pulse that the model does not expect",
                   $time);
          errors++;
        end
        compare_outputs();
      end
    end
  end

endmodule

/* tests/tb_hand_tracker.sv */
`timescale 1ns/100ps

module tb_hand_tracker;
  import camera_pkg::*;
  import track_pkg::*;

  // cycle limits for the bounded waits
  localparam int pulse_wait = 400;
  localparam int quiet_wait = 120;

  logic        clk_65mhz;
  logic        sys_rst;
  logic [7:0]  ja;
  logic [2:0]  jb;
  logic [15:0] sw;
  logic [11:0] hand_x_left_bottom;
  logic [11:0] hand_y_left_bottom;
  logic [11:0] hand_x_left_top;
  logic [11:0] hand_y_left_top;
  logic        transmit_xy_update;
  pix_beat_t   rec;
  bounds_t     bounds;
  logic        check_req;
  int          exp_pulses;
  int          got_pulses;
  int          sb_errors;
  logic [31:0] lcg_state;
  int          fails;
  int          test_no;
  int          mark_errors;
  int          mark_fails;
  logic [15:0] rnd;
  int          lo;

  // upper switches carry the window, the rest stay low
  assign sw = {bounds.upper, bounds.lower, 10'd0};

  tb_clock clock_i (.clk_65mhz(clk_65mhz));

  hand_tracker hand_tracker_i (
    .clk_65mhz          (clk_65mhz),
    .sys_rst            (sys_rst),
    .ja                 (ja),
    .jb                 (jb),
    .sw                 (sw),
    .hand_x_left_bottom (hand_x_left_bottom),
    .hand_y_left_bottom (hand_y_left_bottom),
    .hand_x_left_top    (hand_x_left_top),
    .hand_y_left_top    (hand_y_left_top),
    .transmit_xy_update (transmit_xy_update)
  );

  tb_scoreboard scoreboard_i (
    .clk_65mhz          (clk_65mhz),
    .sys_rst            (sys_rst),
    .rec                (rec),
    .bounds             (bounds),
    .check_req          (check_req),
    .hand_x_left_bottom (hand_x_left_bottom),
    .hand_y_left_bottom (hand_y_left_bottom),
    .hand_x_left_top    (hand_x_left_top),
    .hand_y_left_top    (hand_y_left_top),
    .transmit_xy_update (transmit_xy_update),
    .exp_pulses         (exp_pulses),
    .got_pulses         (got_pulses),
    .errors             (sb_errors)
  );

  // lcg step, upper half is the better half
  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // mode 0 any colour, mode 1 strong red with little green or blue
  function automatic logic [15:0] make_pixel(input int mode);
    logic [15:0] r;
    r = next_random();
    if (mode == 1) begin
      return {3'b111, r[1:0], 4'b0000, r[3:2], 4'b0000, r[4]};
    end
    return r;
  endfunction

  // one pclk period, low half then high half, note shown to the model at the rise
  task automatic pclk_period(input logic href, input logic vsync, input logic [7:0] data,
                             input pix_beat_t note);
    @(negedge clk_65mhz);
    ja = data;
    jb = {href, vsync, 1'b0};
    repeat (4) @(negedge clk_65mhz);
    jb[0] = 1'b1;
    rec = note;
    @(negedge clk_65mhz);
    rec = '0;
    repeat (2) @(negedge clk_65mhz);
  endtask

  // 6 lines of 10 pixels, href gaps, then vsync
  task automatic send_frame(input int mode);
    pix_beat_t   note;
    logic [15:0] pix;
    for (int ln = 0; ln < 6; ln++) begin
      for (int px = 0; px < 10; px++) begin
        pix = make_pixel(mode);
        pclk_period(1'b1, 1'b0, pix[15:8], '0);
        note = '0;
        note.valid = 1'b1;
        note.pixel = pix;
        note.x = 11'(px);
        note.y = 10'(ln);
        pclk_period(1'b1, 1'b0, pix[7:0], note);
      end
      repeat (3) pclk_period(1'b0, 1'b0, 8'h00, '0);
    end
    note = '0;
    note.frame_end = 1'b1;
    pclk_period(1'b0, 1'b1, 8'h00, note);
    repeat (2) pclk_period(1'b0, 1'b1, 8'h00, '0);
    repeat (2) pclk_period(1'b0, 1'b0, 8'h00, '0);
  endtask

  task automatic wait_transmit();
    int n;
    n = 0;
    while (got_pulses < exp_pulses && n < pulse_wait) begin
      @(negedge clk_65mhz);
      n++;
    end
    if (got_pulses < exp_pulses) begin
      $display("test %0d: transmit_xy_update never pulsed within %0d cycles",
               test_no, pulse_wait);
      fails++;
    end
  endtask

  // quiet period, any stray pulse is caught by the scoreboard
  task automatic settle();
    int n;
    n = 0;
    while (n < quiet_wait) begin
      @(negedge clk_65mhz);
      n++;
    end
  endtask

  task automatic request_check();
    @(negedge clk_65mhz);
    check_req = 1'b1;
    @(negedge clk_65mhz);
    check_req = 1'b0;
  endtask

  task automatic set_bounds(input logic [2:0] lower, input logic [2:0] upper);
    @(negedge clk_65mhz);
    bounds.lower = lower;
    bounds.upper = upper;
  endtask

  task automatic run_frame(input int mode);
    send_frame(mode);
    if (got_pulses < exp_pulses) begin
      wait_transmit();
    end
    settle();
    request_check();
  endtask

  task automatic begin_test(input int n);
    test_no = n;
    mark_errors = sb_errors;
    mark_fails = fails;
  endtask

  task automatic end_test(input string name);
    if (sb_errors == mark_errors && fails == mark_fails) begin
      $display("test %0d %s: ok", test_no, name);
    end else begin
      $display("test %0d %s: errors found", test_no, name);
    end
  endtask

  initial begin
    lcg_state = 32'hb25c_3c1f;
    ja = 8'h00;
    jb = 3'b000;
    bounds = '{lower: 3'd0, upper: 3'd7};
    rec = '0;
    check_req = 1'b0;
    fails = 0;
    test_no = 0;
    sys_rst = 1'b1;
    repeat (16) @(negedge clk_65mhz);
    sys_rst = 1'b0;

    // outputs at zero, no pulse while idle
    begin_test(1);
    request_check();
    settle();
    request_check();
    end_test("reset state");

    // full window, every pixel in both masks
    begin_test(2);
    set_bounds(3'd0, 3'd7);
    run_frame(0);
    end_test("both masks hit");

    // lower above upper, nothing passes
    begin_test(3);
    set_bounds(3'd5, 3'd2);
    run_frame(0);
    end_test("empty window");

    // red frame feeds only cr, then a full frame releases the pulse
    begin_test(4);
    set_bounds(3'd6, 3'd7);
    run_frame(1);
    set_bounds(3'd0, 3'd7);
    run_frame(0);
    end_test("cr only then both");

    begin_test(5);
    for (int f = 0; f < 20; f++) begin
      rnd = next_random();
      lo = int'(rnd[2:0]);
      rnd = next_random();
      set_bounds(3'(lo), 3'(lo + int'(rnd) % (8 - lo)));
      run_frame(0);
    end
    end_test("random frames");

    $display("5 tests, %0d of %0d pulses seen, %0d value errors, %0d other failures",
             got_pulses, exp_pulses, sb_errors, fails);
    if (sb_errors == 0 && fails == 0 && got_pulses == exp_pulses) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/camera_pkg.sv
logic/track_pkg.sv
logic/mean_divider.sv
logic/cam_capture.sv
logic/chroma_mask.sv
logic/centroid_accum.sv
logic/hand_report.sv
logic/hand_tracker.sv
tests/tb_clock.sv
tests/tb_scoreboard.sv
tests/tb_hand_tracker.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hand_tracker
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
